// File: rtl/core_pkg.sv
// ==============================
// core side of the data memory port
// word accesses only, no byte or halfword ops
// ==============================
`default_nettype none

package core_pkg;

  // core data width and byte strobes per word
  localparam int XLEN   = 32;
  localparam int STRB_W = XLEN / 8;

  // memory stage operation
  // encoding 2'b11 is unused and treated like MEM_NONE by the router
  typedef enum logic [1:0] {
    MEM_NONE = 2'b00,
    MEM_LW   = 2'b01,
    MEM_SW   = 2'b10
  } mem_op_t;

endpackage

`default_nettype wire

// File: rtl/axil_pkg.sv
// ==============================
// AXI-lite bus widths and memory map
// one peripheral window, rest goes to scratchpad
// ==============================
`default_nettype none

package axil_pkg;

  // bus widths
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;

  // peripheral window, decoded on the top nibble only
  localparam logic [AXIL_ADDR_W-1:0] AXIL_BASE = 32'h4000_0000;
  localparam logic [AXIL_ADDR_W-1:0] AXIL_MASK = 32'hF000_0000;

  // scratchpad size in words, aliased over the whole non-peripheral space
  localparam int SPAD_WORDS = 256;
  localparam int SPAD_AW    = $clog2(SPAD_WORDS);

endpackage

`default_nettype wire

// File: rtl/axil_request.sv
// ==============================
// EN and fields must be held until done
// a request still held after done restarts
// ==============================
`default_nettype none

module axil_request
  import core_pkg::*, axil_pkg::*;
#(
  parameter bit ENABLE_WRITE = 1'b1
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     EN,
  input  mem_op_t                  MEM_OP,
  input  logic [XLEN-1:0]          MEM_WDATA,
  input  logic [STRB_W-1:0]        MEM_WSTRB,
  input  logic [AXIL_ADDR_W-1:0]   AXIL_ADDR,
  // from the master
  input  logic                     AXIL_DONE_READ,
  input  logic                     AXIL_DONE_WRITE,
  input  logic [AXIL_DATA_W-1:0]   AXIL_TRANSACTION_RDATA,
  // toward the master
  output logic                     AXIL_START_READ,
  output logic                     AXIL_START_WRITE,
  output logic [AXIL_ADDR_W-1:0]   AXIL_TRANSACTION_WRADDR,
  output logic [AXIL_DATA_W-1:0]   AXIL_TRANSACTION_WRDATA,
  output logic [AXIL_DATA_W/8-1:0] AXIL_TRANSACTION_WSTRB,
  output logic [AXIL_ADDR_W-1:0]   AXIL_TRANSACTION_RADDR
);

  logic axil_rreq;
  logic axil_rreq_pending;
  logic axil_wreq;
  logic axil_wreq_pending;

  // read side, always present
  always_comb begin
    axil_rreq              = EN && (MEM_OP == MEM_LW);
    AXIL_START_READ        = axil_rreq && !axil_rreq_pending;
    AXIL_TRANSACTION_RADDR = EN ? AXIL_ADDR : '0;
  end

  generate
    if (ENABLE_WRITE) begin : g_write
      always_comb begin
        axil_wreq               = EN && (MEM_OP == MEM_SW);
        AXIL_START_WRITE        = axil_wreq && !axil_wreq_pending;
        AXIL_TRANSACTION_WRADDR = EN ? AXIL_ADDR : '0;
        AXIL_TRANSACTION_WRDATA = EN ? MEM_WDATA : '0;
        AXIL_TRANSACTION_WSTRB  = EN ? MEM_WSTRB : '0;
      end
    end else begin : g_no_write
      // read-only port, stores to the window are never started
      assign axil_wreq               = 1'b0;
      assign AXIL_START_WRITE        = 1'b0;
      assign AXIL_TRANSACTION_WRADDR = '0;
      assign AXIL_TRANSACTION_WRDATA = '0;
      assign AXIL_TRANSACTION_WSTRB  = '0;
    end
  endgenerate

  // pending flags hold off repeated starts while the core waits
  always_ff @(posedge CLK) begin
    if (RST) begin
      axil_rreq_pending <= 1'b0;
      axil_wreq_pending <= 1'b0;
    end else begin
      if (AXIL_DONE_READ) begin
        axil_rreq_pending <= 1'b0;
      end else if (AXIL_START_READ) begin
        axil_rreq_pending <= 1'b1;
      end
      if (AXIL_DONE_WRITE) begin
        axil_wreq_pending <= 1'b0;
      end else if (AXIL_START_WRITE) begin
        axil_wreq_pending <= 1'b1;
      end
    end
  end

  // a done pulse must answer a start issued here, and read data must be clean
  a_done_read_pending: assert property (@(posedge CLK) disable iff (RST)
    AXIL_DONE_READ |-> axil_rreq_pending && !$isunknown(AXIL_TRANSACTION_RDATA));

  a_done_write_pending: assert property (@(posedge CLK) disable iff (RST)
    AXIL_DONE_WRITE |-> axil_wreq_pending);

endmodule

`default_nettype wire

// File: rtl/axil_master.sv
// ==============================
// one transaction at a time, reads win a tie
// RRESP and BRESP are not acted on
// ==============================
`default_nettype none

module axil_master
  import axil_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  // transaction side
  input  logic                     AXIL_START_READ,
  input  logic                     AXIL_START_WRITE,
  input  logic [AXIL_ADDR_W-1:0]   AXIL_TRANSACTION_RADDR,
  input  logic [AXIL_ADDR_W-1:0]   AXIL_TRANSACTION_WRADDR,
  input  logic [AXIL_DATA_W-1:0]   AXIL_TRANSACTION_WRDATA,
  input  logic [AXIL_DATA_W/8-1:0] AXIL_TRANSACTION_WSTRB,
  output logic                     AXIL_DONE_READ,
  output logic                     AXIL_DONE_WRITE,
  output logic [AXIL_DATA_W-1:0]   AXIL_TRANSACTION_RDATA,
  // AXI-lite
  output logic                     awvalid,
  output logic [AXIL_ADDR_W-1:0]   awaddr,
  input  logic                     awready,
  output logic                     wvalid,
  output logic [AXIL_DATA_W-1:0]   wdata,
  output logic [AXIL_DATA_W/8-1:0] wstrb,
  input  logic                     wready,
  input  logic                     bvalid,
  input  logic [1:0]               bresp,
  output logic                     bready,
  output logic                     arvalid,
  output logic [AXIL_ADDR_W-1:0]   araddr,
  input  logic                     arready,
  input  logic                     rvalid,
  input  logic [AXIL_DATA_W-1:0]   rdata,
  input  logic [1:0]               rresp,
  output logic                     rready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ADDR,
    ST_RD_RESP,
    ST_RD_DONE,
    ST_WR_ADDR,
    ST_WR_RESP,
    ST_WR_DONE
  } state_t;

  state_t                   state;
  logic [AXIL_ADDR_W-1:0]   addr_q;
  logic [AXIL_DATA_W-1:0]   wdata_q;
  logic [AXIL_DATA_W/8-1:0] wstrb_q;
  logic [AXIL_DATA_W-1:0]   rdata_q;
  logic                     wr_addr_done;

  // AW and W finish independently; move on once both have handshaked
  assign wr_addr_done = (!awvalid || awready) && (!wvalid || wready);

  always_ff @(posedge CLK) begin
    if (RST) begin
      state   <= ST_IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (AXIL_START_READ) begin
            state <= ST_RD_ADDR;
          end else if (AXIL_START_WRITE) begin
            state   <= ST_WR_ADDR;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
          end
        end
        ST_RD_ADDR: if (arready) state <= ST_RD_RESP;
        ST_RD_RESP: if (rvalid) state <= ST_RD_DONE;
        ST_WR_ADDR: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if (wr_addr_done) state <= ST_WR_RESP;
        end
        ST_WR_RESP: if (bvalid) state <= ST_WR_DONE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // payload is captured once so it stays stable under back-pressure
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE) begin
      if (AXIL_START_READ) begin
        addr_q <= AXIL_TRANSACTION_RADDR;
      end else if (AXIL_START_WRITE) begin
        addr_q  <= AXIL_TRANSACTION_WRADDR;
        wdata_q <= AXIL_TRANSACTION_WRDATA;
        wstrb_q <= AXIL_TRANSACTION_WSTRB;
      end
    end
    if (state == ST_RD_RESP && rvalid) begin
      rdata_q <= rdata;
    end
  end

  assign arvalid = (state == ST_RD_ADDR);
  assign araddr  = addr_q;
  assign awaddr  = addr_q;
  assign wdata   = wdata_q;
  assign wstrb   = wstrb_q;
  assign rready  = (state == ST_RD_RESP);
  assign bready  = (state == ST_WR_RESP);

  // done trails the response handshake by one cycle
  assign AXIL_DONE_READ         = (state == ST_RD_DONE);
  assign AXIL_DONE_WRITE        = (state == ST_WR_DONE);
  assign AXIL_TRANSACTION_RDATA = rdata_q;

  // the request generator only starts after the previous done
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    (AXIL_START_READ || AXIL_START_WRITE) |-> state == ST_IDLE);

  a_arvalid_hold: assert property (@(posedge CLK) disable iff (RST)
    (arvalid && !arready) |=> arvalid && $stable(araddr));

  // response codes are ignored, but the slave must still drive them
  a_rresp_known: assert property (@(posedge CLK) disable iff (RST)
    (rvalid && rready) |-> !$isunknown(rresp));

  a_bresp_known: assert property (@(posedge CLK) disable iff (RST)
    (bvalid && bready) |-> !$isunknown(bresp));

endmodule

`default_nettype wire

// File: rtl/lsu_route.sv
// ==============================
// scratchpad answers one cycle after valid
// peripheral accesses end on a done pulse
// ==============================
`default_nettype none

module lsu_route
  import core_pkg::*, axil_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   mem_valid,
  input  mem_op_t                mem_op,
  input  logic [XLEN-1:0]        mem_addr,
  input  logic [XLEN-1:0]        mem_wdata,
  input  logic [STRB_W-1:0]      mem_wstrb,
  input  logic                   axil_done_read,
  input  logic                   axil_done_write,
  input  logic [AXIL_DATA_W-1:0] axil_rdata,
  output logic                   axil_en,
  output logic                   mem_ready,
  output logic [XLEN-1:0]        mem_rdata
);

  logic [XLEN-1:0]    spad_mem [SPAD_WORDS];
  logic [XLEN-1:0]    spad_rdata;
  logic [SPAD_AW-1:0] spad_idx;
  logic               is_periph;
  logic               is_ldst;
  logic               spad_hit;
  logic               spad_start;
  logic               spad_busy;
  logic               none_done;

  // address decode
  assign is_periph = (mem_addr & AXIL_MASK) == AXIL_BASE;
  assign is_ldst   = (mem_op == MEM_LW) || (mem_op == MEM_SW);

  assign axil_en    = mem_valid && is_periph && is_ldst;
  assign spad_hit   = mem_valid && !is_periph && is_ldst;
  assign spad_start = spad_hit && !spad_busy;
  assign none_done  = mem_valid && !is_ldst;

  // word index, wraps over SPAD_WORDS
  assign spad_idx = mem_addr[SPAD_AW+1:2];

  // busy covers exactly the cycle after the access is taken
  always_ff @(posedge CLK) begin
    if (RST) begin
      spad_busy <= 1'b0;
    end else if (spad_busy) begin
      spad_busy <= 1'b0;
    end else if (spad_hit) begin
      spad_busy <= 1'b1;
    end
  end

  // read sees the old word, write lands in the same edge
  always_ff @(posedge CLK) begin
    if (spad_start) begin
      spad_rdata <= spad_mem[spad_idx];
      if (mem_op == MEM_SW) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (mem_wstrb[b]) spad_mem[spad_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // merge both paths back to the core
  assign mem_ready = spad_busy || axil_done_read || axil_done_write || none_done;
  assign mem_rdata = axil_done_read ? axil_rdata : spad_rdata;

  // the core holds its request until ready
  a_op_held: assert property (@(posedge CLK) disable iff (RST)
    (mem_valid && !mem_ready) |=> $stable(mem_op));

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
// ==============================
// core request must be held until mem_ready
// ==============================
`default_nettype none

module lsu_top
  import core_pkg::*, axil_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  // core side
  input  logic                     mem_valid,
  input  mem_op_t                  mem_op,
  input  logic [XLEN-1:0]          mem_addr,
  input  logic [XLEN-1:0]          mem_wdata,
  input  logic [STRB_W-1:0]        mem_wstrb,
  output logic                     mem_ready,
  output logic [XLEN-1:0]          mem_rdata,
  // AXI-lite
  output logic                     awvalid,
  output logic [AXIL_ADDR_W-1:0]   awaddr,
  input  logic                     awready,
  output logic                     wvalid,
  output logic [AXIL_DATA_W-1:0]   wdata,
  output logic [AXIL_DATA_W/8-1:0] wstrb,
  input  logic                     wready,
  input  logic                     bvalid,
  input  logic [1:0]               bresp,
  output logic                     bready,
  output logic                     arvalid,
  output logic [AXIL_ADDR_W-1:0]   araddr,
  input  logic                     arready,
  input  logic                     rvalid,
  input  logic [AXIL_DATA_W-1:0]   rdata,
  input  logic [1:0]               rresp,
  output logic                     rready
);

  logic                     axil_en;
  logic                     start_read;
  logic                     start_write;
  logic                     done_read;
  logic                     done_write;
  logic [AXIL_ADDR_W-1:0]   tr_raddr;
  logic [AXIL_ADDR_W-1:0]   tr_wraddr;
  logic [AXIL_DATA_W-1:0]   tr_wrdata;
  logic [AXIL_DATA_W/8-1:0] tr_wstrb;
  logic [AXIL_DATA_W-1:0]   tr_rdata;

  lsu_route i_route (
    .CLK             (CLK),
    .RST             (RST),
    .mem_valid       (mem_valid),
    .mem_op          (mem_op),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_wstrb       (mem_wstrb),
    .axil_done_read  (done_read),
    .axil_done_write (done_write),
    .axil_rdata      (tr_rdata),
    .axil_en         (axil_en),
    .mem_ready       (mem_ready),
    .mem_rdata       (mem_rdata)
  );

  axil_request #(
    .ENABLE_WRITE (1'b1)
  ) i_request (
    .CLK                     (CLK),
    .RST                     (RST),
    .EN                      (axil_en),
    .MEM_OP                  (mem_op),
    .MEM_WDATA               (mem_wdata),
    .MEM_WSTRB               (mem_wstrb),
    .AXIL_ADDR               (mem_addr),
    .AXIL_DONE_READ          (done_read),
    .AXIL_DONE_WRITE         (done_write),
    .AXIL_TRANSACTION_RDATA  (tr_rdata),
    .AXIL_START_READ         (start_read),
    .AXIL_START_WRITE        (start_write),
    .AXIL_TRANSACTION_WRADDR (tr_wraddr),
    .AXIL_TRANSACTION_WRDATA (tr_wrdata),
    .AXIL_TRANSACTION_WSTRB  (tr_wstrb),
    .AXIL_TRANSACTION_RADDR  (tr_raddr)
  );

  axil_master i_master (
    .CLK                     (CLK),
    .RST                     (RST),
    .AXIL_START_READ         (start_read),
    .AXIL_START_WRITE        (start_write),
    .AXIL_TRANSACTION_RADDR  (tr_raddr),
    .AXIL_TRANSACTION_WRADDR (tr_wraddr),
    .AXIL_TRANSACTION_WRDATA (tr_wrdata),
    .AXIL_TRANSACTION_WSTRB  (tr_wstrb),
    .AXIL_DONE_READ          (done_read),
    .AXIL_DONE_WRITE         (done_write),
    .AXIL_TRANSACTION_RDATA  (tr_rdata),
    .awvalid                 (awvalid),
    .awaddr                  (awaddr),
    .awready                 (awready),
    .wvalid                  (wvalid),
    .wdata                   (wdata),
    .wstrb                   (wstrb),
    .wready                  (wready),
    .bvalid                  (bvalid),
    .bresp                   (bresp),
    .bready                  (bready),
    .arvalid                 (arvalid),
    .araddr                  (araddr),
    .arready                 (arready),
    .rvalid                  (rvalid),
    .rdata                   (rdata),
    .rresp                   (rresp),
    .rready                  (rready)
  );

endmodule

`default_nettype wire

// File: bench/tb_lsu_top.sv
// ==============================
// random word loads and stores to scratchpad and peripheral window
// slave answers with random ready delays, one access at a time
// ==============================
`default_nettype none

module tb_lsu_top
  import core_pkg::*, axil_pkg::*;
;

  localparam int          CLK_PERIOD = 20;
  localparam logic [31:0] SEED       = 32'h39651fa0;
  localparam int          NUM_INIT   = 16;
  localparam int          NUM_DIRECT = 12;
  localparam int          NUM_RAND   = 400;
  localparam int          NUM_ALL    = NUM_INIT + NUM_DIRECT + NUM_RAND;

  logic                     CLK = 1'b0;
  logic                     RST;
  logic                     mem_valid;
  mem_op_t                  mem_op;
  logic [XLEN-1:0]          mem_addr;
  logic [XLEN-1:0]          mem_wdata;
  logic [STRB_W-1:0]        mem_wstrb;
  logic                     mem_ready;
  logic [XLEN-1:0]          mem_rdata;
  logic                     awvalid;
  logic [AXIL_ADDR_W-1:0]   awaddr;
  logic                     awready;
  logic                     wvalid;
  logic [AXIL_DATA_W-1:0]   wdata;
  logic [AXIL_DATA_W/8-1:0] wstrb;
  logic                     wready;
  logic                     bvalid;
  logic [1:0]               bresp;
  logic                     bready;
  logic                     arvalid;
  logic [AXIL_ADDR_W-1:0]   araddr;
  logic                     arready;
  logic                     rvalid;
  logic [AXIL_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rready;

  // reference model and random state
  logic [XLEN-1:0]   spad_ref [16];
  logic [XLEN-1:0]   periph_ref [32];
  logic [31:0]       stim_rng;
  logic [31:0]       slave_rng;
  // access currently held by the core, seen by the slave monitor
  logic [XLEN-1:0]   cur_addr;
  logic [XLEN-1:0]   cur_wdata;
  logic [STRB_W-1:0] cur_wstrb;
  // handshake totals, written only by the slave process
  int                ar_total;
  int                aw_total;
  int                w_total;
  // sparse slave memory keyed by word address
  logic [31:0]       slave_mem [logic [31:0]];

  lsu_top i_dut (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_word,
      input logic [XLEN-1:0] new_word, input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] w;
    w = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  // untouched slave words read back as a pattern of their address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [31:0] slave_read(input logic [31:0] a);
    if (slave_mem.exists(a)) return slave_mem[a];
    return fill_word(a);
  endfunction

  function automatic int next_delay();
    slave_rng = xorshift32(slave_rng);
    return int'(slave_rng[1:0]);
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
      input logic [XLEN-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_strb(input string name, input logic [STRB_W-1:0] exp,
      input logic [STRB_W-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_op(input string name, input mem_op_t exp, input mem_op_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s: expected %s, actual %s", name,
                                exp.name(), act.name()));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_idle(input string name);
    check_bit({name, " mem_ready"}, 1'b0, mem_ready);
    check_bit({name, " arvalid"}, 1'b0, arvalid);
    check_bit({name, " awvalid"}, 1'b0, awvalid);
    check_bit({name, " wvalid"}, 1'b0, wvalid);
    check_bit({name, " rready"}, 1'b0, rready);
    check_bit({name, " bready"}, 1'b0, bready);
  endtask

  // present one access, hold it until mem_ready, then check against the model
  task automatic run_access(input string tag, input mem_op_t op, input logic [XLEN-1:0] addr,
      input logic [XLEN-1:0] wd, input logic [STRB_W-1:0] strb);
    int              cyc;
    int              ar0;
    int              aw0;
    int              w0;
    logic            periph;
    mem_op_t         dir_exp;
    mem_op_t         dir_obs;
    logic [XLEN-1:0] exp_rdata;
    logic [XLEN-1:0] got_rdata;
    periph    = (addr & AXIL_MASK) == AXIL_BASE;
    dir_exp   = (op != MEM_NONE && periph) ? op : MEM_NONE;
    exp_rdata = periph ? periph_ref[addr[6:2]] : spad_ref[addr[5:2]];
    ar0 = ar_total;
    aw0 = aw_total;
    w0  = w_total;
    cur_addr  = addr;
    cur_wdata = wd;
    cur_wstrb = strb;
    mem_valid = 1'b1;
    mem_op    = op;
    mem_addr  = addr;
    mem_wdata = wd;
    mem_wstrb = strb;
    cyc = 0;
    @(negedge CLK);
    while (!mem_ready) begin
      cyc++;
      @(posedge CLK);
      #2;
      @(negedge CLK);
    end
    got_rdata = mem_rdata;
    @(posedge CLK);
    #2;
    mem_valid = 1'b0;
    mem_op    = MEM_NONE;
    if (op == MEM_NONE) begin
      check_bit($sformatf("%s none ready after %0d", tag, cyc), 1'b1, cyc == 0);
    end else if (!periph) begin
      check_bit($sformatf("%s spad ready after %0d", tag, cyc), 1'b1, cyc == 1);
    end
    if (op == MEM_LW) check_word({tag, " rdata"}, exp_rdata, got_rdata);
    if (ar_total != ar0) dir_obs = MEM_LW;
    else if (aw_total != aw0) dir_obs = MEM_SW;
    else dir_obs = MEM_NONE;
    check_op({tag, " axi direction"}, dir_exp, dir_obs);
    check_bit($sformatf("%s ar count %0d", tag, ar_total - ar0), 1'b1,
              (ar_total - ar0) == (dir_exp == MEM_LW ? 1 : 0));
    check_bit($sformatf("%s aw count %0d", tag, aw_total - aw0), 1'b1,
              (aw_total - aw0) == (dir_exp == MEM_SW ? 1 : 0));
    check_bit($sformatf("%s w count %0d", tag, w_total - w0), 1'b1,
              (w_total - w0) == (dir_exp == MEM_SW ? 1 : 0));
    if (op == MEM_SW && periph) begin
      periph_ref[addr[6:2]] = merge_bytes(periph_ref[addr[6:2]], wd, strb);
    end else if (op == MEM_SW) begin
      spad_ref[addr[5:2]] = merge_bytes(spad_ref[addr[5:2]], wd, strb);
    end
  endtask

  function automatic logic [XLEN-1:0] spad_addr(input logic [31:0] r, input logic [3:0] idx);
    logic [3:0] top;
    top = (r[31:28] == 4'h4) ? 4'h0 : r[31:28];
    return {top, r[27:10], 4'b0000, idx, 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] periph_addr(input logic [4:0] idx);
    return AXIL_BASE | {25'b0, idx, 2'b00};
  endfunction

  // stimulus
  initial begin
    logic [31:0]       r;
    logic [XLEN-1:0]   a;
    mem_op_t           op;
    RST       = 1'b1;
    mem_valid = 1'b0;
    mem_op    = MEM_NONE;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    cur_addr  = '0;
    cur_wdata = '0;
    cur_wstrb = '0;
    stim_rng  = SEED;
    for (int i = 0; i < 32; i++) begin
      periph_ref[i] = fill_word(periph_addr(5'(i)));
    end
    repeat (4) @(posedge CLK);
    #2;
    RST = 1'b0;
    repeat (3) begin
      @(negedge CLK);
      check_idle("after reset");
      @(posedge CLK);
      #2;
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      stim_rng = xorshift32(stim_rng);
      run_access("spad init", MEM_SW, spad_addr(stim_rng, 4'(i)), stim_rng ^ 32'h1234_5678,
                 4'hf);
    end
    // back-to-back peripheral accesses of one type, no idle cycles
    for (int i = 0; i < NUM_DIRECT; i++) begin
      stim_rng = xorshift32(stim_rng);
      op = (i >= 4 && i < 8) ? MEM_SW : MEM_LW;
      run_access("periph b2b", op, periph_addr(5'(i % 4)), stim_rng, stim_rng[7:4]);
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      stim_rng = xorshift32(stim_rng);
      r = stim_rng;
      case (r[2:0])
        3'd0: op = MEM_NONE;
        3'd1, 3'd2, 3'd3: op = MEM_LW;
        default: op = MEM_SW;
      endcase
      a = r[3] ? periph_addr(r[8:4]) : spad_addr(xorshift32(r), r[7:4]);
      stim_rng = xorshift32(stim_rng);
      run_access($sformatf("random %0d", n), op, a, stim_rng, r[12:9]);
      if (r[13]) begin
        @(posedge CLK);
        #2;
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // AXI-lite slave model and channel monitor
  initial begin
    logic        ar_hs, aw_hs, w_hs, r_hs, b_hs;
    logic        ar_held, aw_held, w_held;
    logic [31:0] ar_prev, aw_prev, wd_prev;
    logic [3:0]  ws_prev;
    int          ar_wait, aw_wait, w_wait, r_wait, b_wait;
    logic        r_pend, b_pend, aw_got, w_got;
    logic [31:0] r_addr_q, aw_addr_q, w_data_q;
    logic [3:0]  w_strb_q;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = 2'b00;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = 2'b00;
    ar_total = 0;
    aw_total = 0;
    w_total  = 0;
    slave_rng = xorshift32(SEED ^ 32'h0000_ffff);
    ar_held = 1'b0;
    aw_held = 1'b0;
    w_held  = 1'b0;
    ar_prev = '0;
    aw_prev = '0;
    wd_prev = '0;
    ws_prev = '0;
    r_pend  = 1'b0;
    b_pend  = 1'b0;
    aw_got  = 1'b0;
    w_got   = 1'b0;
    r_addr_q  = '0;
    aw_addr_q = '0;
    w_data_q  = '0;
    w_strb_q  = '0;
    ar_wait = next_delay();
    aw_wait = next_delay();
    w_wait  = next_delay();
    r_wait  = 0;
    b_wait  = 0;
    forever begin
      // values here hold through the next rising edge
      @(negedge CLK);
      ar_hs = arvalid && arready;
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      r_hs  = rvalid && rready;
      b_hs  = bvalid && bready;
      if (ar_held) begin
        check_bit("arvalid held", 1'b1, arvalid);
        check_word("araddr stable", ar_prev, araddr);
      end
      if (aw_held) begin
        check_bit("awvalid held", 1'b1, awvalid);
        check_word("awaddr stable", aw_prev, awaddr);
      end
      if (w_held) begin
        check_bit("wvalid held", 1'b1, wvalid);
        check_word("wdata stable", wd_prev, wdata);
        check_strb("wstrb stable", ws_prev, wstrb);
      end
      if (ar_hs) begin
        ar_total++;
        check_word("araddr", cur_addr, araddr);
        r_addr_q = araddr;
        r_pend   = 1'b1;
        r_wait   = next_delay();
      end
      if (aw_hs) begin
        aw_total++;
        check_word("awaddr", cur_addr, awaddr);
        aw_addr_q = awaddr;
        aw_got    = 1'b1;
      end
      if (w_hs) begin
        w_total++;
        check_word("wdata", cur_wdata, wdata);
        check_strb("wstrb", cur_wstrb, wstrb);
        w_data_q = wdata;
        w_strb_q = wstrb;
        w_got    = 1'b1;
      end
      ar_held = arvalid && !arready;
      aw_held = awvalid && !awready;
      w_held  = wvalid && !wready;
      ar_prev = araddr;
      aw_prev = awaddr;
      wd_prev = wdata;
      ws_prev = wstrb;
      @(posedge CLK);
      #2;
      if (ar_hs) begin
        arready = 1'b0;
        ar_wait = next_delay();
      end else if (ar_held) begin
        if (ar_wait == 0) arready = 1'b1;
        else ar_wait--;
      end
      if (aw_hs) begin
        awready = 1'b0;
        aw_wait = next_delay();
      end else if (aw_held) begin
        if (aw_wait == 0) awready = 1'b1;
        else aw_wait--;
      end
      if (w_hs) begin
        wready = 1'b0;
        w_wait = next_delay();
      end else if (w_held) begin
        if (w_wait == 0) wready = 1'b1;
        else w_wait--;
      end
      // commit the write once address and data have both arrived
      if (aw_got && w_got) begin
        slave_mem[aw_addr_q] = merge_bytes(slave_read(aw_addr_q), w_data_q, w_strb_q);
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
        b_wait = next_delay();
      end
      if (r_hs) begin
        rvalid = 1'b0;
        r_pend = 1'b0;
      end else if (r_pend && !rvalid) begin
        if (r_wait == 0) begin
          rvalid = 1'b1;
          rdata  = slave_read(r_addr_q);
        end else begin
          r_wait--;
        end
      end
      if (b_hs) begin
        bvalid = 1'b0;
        b_pend = 1'b0;
      end else if (b_pend && !bvalid) begin
        if (b_wait == 0) bvalid = 1'b1;
        else b_wait--;
      end
    end
  end

  // 40 cycles per access plus reset and idle margin
  initial begin
    #(CLK_PERIOD * (40 * NUM_ALL + 20));
    $display("watchdog expired: the accesses did not finish in the allowed time");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/core_pkg.sv
rtl/axil_pkg.sv
rtl/axil_request.sv
rtl/axil_master.sv
rtl/lsu_route.sv
rtl/lsu_top.sv
bench/tb_lsu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_lsu_top \
    -Mdir obj_dir -f sources.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_lsu_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

exit 0
